// File: source/cpuTypesPkg.sv
// Shared MIPS types: data word, register index, opcodes, function codes, ALU ops, fixed addresses
package cpuTypesPkg;

  localparam int WORD_W = 32;
  localparam int REG_W = 5;

  typedef logic [WORD_W-1:0] word_t;  // Data word or byte address
  typedef logic [REG_W-1:0] regBits_t;  // Register index

  // Major opcodes, instr[31:26]
  typedef enum logic [5:0] {
    RTYPE = 6'b000000,
    J     = 6'b000010,
    JAL   = 6'b000011,
    BEQ   = 6'b000100,
    BNE   = 6'b000101,
    ADDI  = 6'b001000,
    ADDIU = 6'b001001,
    SLTI  = 6'b001010,
    SLTIU = 6'b001011,
    ANDI  = 6'b001100,
    ORI   = 6'b001101,
    XORI  = 6'b001110,
    LUI   = 6'b001111,
    LW    = 6'b100011,
    SW    = 6'b101011,
    HALT  = 6'b111111
  } opcode_t;

  // R-type function codes, instr[5:0]
  typedef enum logic [5:0] {
    SLL  = 6'b000000,
    SRL  = 6'b000010,
    JR   = 6'b001000,
    ADD  = 6'b100000,
    ADDU = 6'b100001,
    SUB  = 6'b100010,
    SUBU = 6'b100011,
    AND  = 6'b100100,
    OR   = 6'b100101,
    XOR  = 6'b100110,
    NOR  = 6'b100111,
    SLT  = 6'b101010,
    SLTU = 6'b101011
  } funct_t;

  // ALU operation select
  typedef enum logic [3:0] {
    ALU_SLL  = 4'd0,
    ALU_SRL  = 4'd1,
    ALU_ADD  = 4'd2,
    ALU_SUB  = 4'd3,
    ALU_AND  = 4'd4,
    ALU_OR   = 4'd5,
    ALU_XOR  = 4'd6,
    ALU_NOR  = 4'd7,
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9
  } aluOp_t;

  // First instruction fetched after reset
  localparam word_t PC_RESET = '0;

  // Return address register written by JAL
  localparam regBits_t LINK_REG = 5'd31;

endpackage

// File: source/controlUnit.sv
// Instruction decoder producing single-cycle datapath control levels and the ALU operation
`timescale 1ns/1ps

module controlUnit (
  input cpuTypesPkg::word_t instr,
  output logic regDst,
  output logic aluSrc,
  output logic memToReg,
  output logic regWen,
  output logic dRen,
  output logic dWen,
  output logic branch,
  output logic bne,
  output logic jmp,
  output logic jl,
  output logic jmpReg,
  output logic shiftSel,
  output logic zeroExt,
  output logic lui,
  output logic halting,
  output cpuTypesPkg::aluOp_t aluOp
);

  cpuTypesPkg::opcode_t opcode;
  cpuTypesPkg::funct_t funct;
  logic immWrite;  // I-type ops that write rt from the ALU path

  assign opcode = cpuTypesPkg::opcode_t'(instr[31:26]);
  assign funct = cpuTypesPkg::funct_t'(instr[5:0]);

  assign immWrite = opcode inside {cpuTypesPkg::ADDI, cpuTypesPkg::ADDIU, cpuTypesPkg::SLTI,
                                   cpuTypesPkg::SLTIU, cpuTypesPkg::ANDI, cpuTypesPkg::ORI,
                                   cpuTypesPkg::XORI, cpuTypesPkg::LUI, cpuTypesPkg::LW};

  always_comb begin
    // Nothing written unless an instruction asks for it
    regDst = 1'b0;
    aluSrc = 1'b0;
    memToReg = 1'b0;
    regWen = 1'b0;
    dRen = 1'b0;
    dWen = 1'b0;
    branch = 1'b0;
    bne = 1'b0;
    jmp = 1'b0;
    jl = 1'b0;
    jmpReg = 1'b0;
    shiftSel = 1'b0;
    zeroExt = 1'b0;
    lui = 1'b0;
    halting = 1'b0;
    aluOp = cpuTypesPkg::ALU_ADD;

    // Class defaults for immediate write-back
    if (immWrite) begin
      aluSrc = 1'b1;
      regWen = 1'b1;
    end

    case (opcode)
      cpuTypesPkg::RTYPE: begin
        regDst = 1'b1;  // Write rd
        regWen = 1'b1;
        case (funct)
          cpuTypesPkg::SLL: begin
            shiftSel = 1'b1;  // shamt into port A
            aluOp = cpuTypesPkg::ALU_SLL;
          end
          cpuTypesPkg::SRL: begin
            shiftSel = 1'b1;
            aluOp = cpuTypesPkg::ALU_SRL;
          end
          cpuTypesPkg::JR: begin
            regWen = 1'b0;
            jmpReg = 1'b1;
          end
          cpuTypesPkg::ADD, cpuTypesPkg::ADDU: aluOp = cpuTypesPkg::ALU_ADD;  // No overflow trap
          cpuTypesPkg::SUB, cpuTypesPkg::SUBU: aluOp = cpuTypesPkg::ALU_SUB;
          cpuTypesPkg::AND: aluOp = cpuTypesPkg::ALU_AND;
          cpuTypesPkg::OR: aluOp = cpuTypesPkg::ALU_OR;
          cpuTypesPkg::XOR: aluOp = cpuTypesPkg::ALU_XOR;
          cpuTypesPkg::NOR: aluOp = cpuTypesPkg::ALU_NOR;
          cpuTypesPkg::SLT: aluOp = cpuTypesPkg::ALU_SLT;
          cpuTypesPkg::SLTU: aluOp = cpuTypesPkg::ALU_SLTU;
          default: regWen = 1'b0;  // Unknown funct
        endcase
      end
      cpuTypesPkg::SLTI: aluOp = cpuTypesPkg::ALU_SLT;
      cpuTypesPkg::SLTIU: aluOp = cpuTypesPkg::ALU_SLTU;
      cpuTypesPkg::ANDI: begin
        aluOp = cpuTypesPkg::ALU_AND;
        zeroExt = 1'b1;
      end
      cpuTypesPkg::ORI: begin
        aluOp = cpuTypesPkg::ALU_OR;
        zeroExt = 1'b1;
      end
      cpuTypesPkg::XORI: begin
        aluOp = cpuTypesPkg::ALU_XOR;
        zeroExt = 1'b1;
      end
      cpuTypesPkg::LUI: lui = 1'b1;
      cpuTypesPkg::LW: begin
        dRen = 1'b1;
        memToReg = 1'b1;
      end
      cpuTypesPkg::SW: begin
        aluSrc = 1'b1;  // Base plus offset
        dWen = 1'b1;
      end
      cpuTypesPkg::BEQ: begin
        branch = 1'b1;
        aluOp = cpuTypesPkg::ALU_SUB;  // Zero flag on equality
      end
      cpuTypesPkg::BNE: begin
        branch = 1'b1;
        bne = 1'b1;
        aluOp = cpuTypesPkg::ALU_SUB;
      end
      cpuTypesPkg::J: jmp = 1'b1;
      cpuTypesPkg::JAL: begin
        jmp = 1'b1;
        jl = 1'b1;
        regWen = 1'b1;  // Link into r31
      end
      cpuTypesPkg::HALT: halting = 1'b1;
      default: ;  // ADDI, ADDIU use class defaults; unknown opcodes stay idle
    endcase
  end

  // Data port is either read or written, never both
  assert final (!(dRen && dWen)) else $error("Load and store decoded together");

  // Stores never write back
  assert final (!(dWen && regWen)) else $error("Store decoded with register write");

endmodule

// File: source/alu.sv
// 32-bit ALU with shifts, add and subtract, bitwise logic, signed and unsigned compare, zero flag
`timescale 1ns/1ps

module alu (
  input cpuTypesPkg::word_t portA,
  input cpuTypesPkg::word_t portB,
  input cpuTypesPkg::aluOp_t aluOp,
  output cpuTypesPkg::word_t result,
  output logic zero
);

  logic lessSigned;
  logic lessUnsigned;
  logic [4:0] shamt;

  assign shamt = portA[4:0];  // Shift distance from port A
  assign lessSigned = $signed(portA) < $signed(portB);
  assign lessUnsigned = portA < portB;

  always_comb begin
    case (aluOp)
      cpuTypesPkg::ALU_SLL: result = portB << shamt;
      cpuTypesPkg::ALU_SRL: result = portB >> shamt;  // Logical, zero fill
      cpuTypesPkg::ALU_ADD: result = portA + portB;
      cpuTypesPkg::ALU_SUB: result = portA - portB;
      cpuTypesPkg::ALU_AND: result = portA & portB;
      cpuTypesPkg::ALU_OR: result = portA | portB;
      cpuTypesPkg::ALU_XOR: result = portA ^ portB;
      cpuTypesPkg::ALU_NOR: result = ~(portA | portB);
      cpuTypesPkg::ALU_SLT: result = {31'b0, lessSigned};
      cpuTypesPkg::ALU_SLTU: result = {31'b0, lessUnsigned};
      default: result = '0;
    endcase
  end

  // Used by BEQ and BNE
  assign zero = (result == '0);

endmodule

// File: source/registerFile.sv
// 32 by 32 register file, two combinational read ports, one clocked write port, r0 hardwired
`timescale 1ns/1ps

module registerFile (
  input logic CLK,
  input logic rstN,
  input logic wen,
  input cpuTypesPkg::regBits_t wsel,
  input cpuTypesPkg::regBits_t rsel1,
  input cpuTypesPkg::regBits_t rsel2,
  input cpuTypesPkg::word_t wdat,
  output cpuTypesPkg::word_t rdat1,
  output cpuTypesPkg::word_t rdat2
);

  cpuTypesPkg::word_t regs [32];

  always_ff @(posedge CLK or negedge rstN) begin
    if (!rstN) begin
      regs <= '{default: '0};
    end else if (wen && (wsel != '0)) begin  // Writes to r0 dropped
      regs[wsel] <= wdat;
    end
  end

  // Combinational reads, new value visible after the edge
  assign rdat1 = regs[rsel1];
  assign rdat2 = regs[rsel2];

  // r0 must read zero across every write cycle
  assert property (@(posedge CLK) disable iff (!rstN) regs[0] == '0)
    else $error("Register zero changed to %h", regs[0]);

endmodule

// File: source/programCounter.sv
// Program counter with sequential, branch, jump and jump-register next address and halt latch
`timescale 1ns/1ps

module programCounter (
  input logic CLK,
  input logic rstN,
  input logic branch,
  input logic bne,
  input logic jmp,
  input logic jl,
  input logic jmpReg,
  input logic halting,
  input logic zero,
  input cpuTypesPkg::word_t immExt,
  input cpuTypesPkg::word_t jumpReg,
  input logic [25:0] jumpTarget,
  output cpuTypesPkg::word_t pc,
  output logic halt
);

  cpuTypesPkg::word_t pcPlus4;
  cpuTypesPkg::word_t branchAddr;
  cpuTypesPkg::word_t jumpAddr;
  cpuTypesPkg::word_t nextPc;
  logic branchTaken;

  assign pcPlus4 = pc + 32'd4;
  assign branchAddr = pcPlus4 + {immExt[29:0], 2'b00};  // Word offset from delay slot address
  assign jumpAddr = {pcPlus4[31:28], jumpTarget, 2'b00};
  assign branchTaken = branch && (bne ? !zero : zero);

  always_comb begin
    nextPc = pcPlus4;
    if (jmpReg) begin
      nextPc = jumpReg;
    end else if (jmp || jl) begin
      nextPc = jumpAddr;
    end else if (branchTaken) begin
      nextPc = branchAddr;
    end
  end

  always_ff @(posedge CLK or negedge rstN) begin
    if (!rstN) begin
      pc <= cpuTypesPkg::PC_RESET;
      halt <= 1'b0;
    end else begin
      halt <= halt || halting;  // Sticky until reset
      if (!halt && !halting) begin
        pc <= nextPc;  // Frozen on HALT
      end
    end
  end

  // Every fetch address is a word address
  assert property (@(posedge CLK) disable iff (!rstN) pc[1:0] == 2'b00)
    else $error("Unaligned pc %h", pc);

endmodule

// File: source/singleCycleCpu.sv
// Single-cycle MIPS top level with operand, write-back and destination selection
`timescale 1ns/1ps

module singleCycleCpu (
  input logic CLK,
  input logic rstN,
  input cpuTypesPkg::word_t imemLoad,
  input cpuTypesPkg::word_t dmemLoad,
  output cpuTypesPkg::word_t imemAddr,
  output cpuTypesPkg::word_t dmemAddr,
  output cpuTypesPkg::word_t dmemStore,
  output logic dmemRen,
  output logic dmemWen,
  output logic halt
);

  logic regDst, aluSrc, memToReg, regWen, dRen, dWen;
  logic branch, bne, jmp, jl, jmpReg, shiftSel, zeroExt, lui, halting;
  logic zero;
  cpuTypesPkg::aluOp_t aluOp;
  cpuTypesPkg::regBits_t rs, rt, rd, wsel;
  logic [4:0] shamt;
  logic [15:0] imm;
  cpuTypesPkg::word_t immSext, immZext, portA, portB, aluResult;
  cpuTypesPkg::word_t rdat1, rdat2, wdat, pc, linkAddr;

  // Instruction fields
  assign rs = imemLoad[25:21];
  assign rt = imemLoad[20:16];
  assign rd = imemLoad[15:11];
  assign shamt = imemLoad[10:6];
  assign imm = imemLoad[15:0];

  assign immSext = {{16{imm[15]}}, imm};
  assign immZext = {16'b0, imm};
  assign linkAddr = pc + 32'd4;  // JAL return address

  assign portA = shiftSel ? {27'b0, shamt} : rdat1;
  assign portB = aluSrc ? (zeroExt ? immZext : immSext) : rdat2;

  always_comb begin
    if (jl) wdat = linkAddr;
    else if (lui) wdat = {imm, 16'b0};
    else if (memToReg) wdat = dmemLoad;
    else wdat = aluResult;
  end

  assign wsel = jl ? cpuTypesPkg::LINK_REG : (regDst ? rd : rt);

  assign imemAddr = pc;
  assign dmemAddr = aluResult;
  assign dmemStore = rdat2;
  assign dmemRen = dRen && !halt;  // No memory traffic once halted
  assign dmemWen = dWen && !halt;

  controlUnit decoder (
    .instr(imemLoad), .regDst(regDst), .aluSrc(aluSrc), .memToReg(memToReg),
    .regWen(regWen), .dRen(dRen), .dWen(dWen), .branch(branch), .bne(bne),
    .jmp(jmp), .jl(jl), .jmpReg(jmpReg), .shiftSel(shiftSel), .zeroExt(zeroExt),
    .lui(lui), .halting(halting), .aluOp(aluOp)
  );

  alu aluUnit (
    .portA(portA), .portB(portB), .aluOp(aluOp), .result(aluResult), .zero(zero)
  );

  registerFile regFile (
    .CLK(CLK), .rstN(rstN), .wen(regWen), .wsel(wsel), .rsel1(rs), .rsel2(rt),
    .wdat(wdat), .rdat1(rdat1), .rdat2(rdat2)
  );

  programCounter pcUnit (
    .CLK(CLK), .rstN(rstN), .branch(branch), .bne(bne), .jmp(jmp), .jl(jl),
    .jmpReg(jmpReg), .halting(halting), .zero(zero), .immExt(immSext),
    .jumpReg(rdat1), .jumpTarget(imemLoad[25:0]), .pc(pc), .halt(halt)
  );

endmodule

// File: test/cpuTb.sv
// Testbench for singleCycleCpu with memory models, operation table, store checks and timeout
`timescale 1ns/1ps

module cpuTb;

  typedef struct packed {
    cpuTypesPkg::opcode_t op;
    cpuTypesPkg::funct_t fn;
    logic [15:0] imm;  // Immediate, or shift amount for SLL and SRL
    logic [15:0] addr;  // Store address of the result
  } opRow_t;

  localparam int NUM_ROWS = 20;

  opRow_t rows [NUM_ROWS] = '{
    '{cpuTypesPkg::RTYPE, cpuTypesPkg::ADD, 16'h0000, 16'h0100},
    '{cpuTypesPkg::RTYPE, cpuTypesPkg::ADDU, 16'h0000, 16'h0104},
    '{cpuTypesPkg::RTYPE, cpuTypesPkg::SUB, 16'h0000, 16'h0108},
    '{cpuTypesPkg::RTYPE, cpuTypesPkg::SUBU, 16'h0000, 16'h010C},
    '{cpuTypesPkg::RTYPE, cpuTypesPkg::AND, 16'h0000, 16'h0110},
    '{cpuTypesPkg::RTYPE, cpuTypesPkg::OR, 16'h0000, 16'h0114},
    '{cpuTypesPkg::RTYPE, cpuTypesPkg::XOR, 16'h0000, 16'h0118},
    '{cpuTypesPkg::RTYPE, cpuTypesPkg::NOR, 16'h0000, 16'h011C},
    '{cpuTypesPkg::RTYPE, cpuTypesPkg::SLT, 16'h0000, 16'h0120},
    '{cpuTypesPkg::RTYPE, cpuTypesPkg::SLTU, 16'h0000, 16'h0124},
    '{cpuTypesPkg::RTYPE, cpuTypesPkg::SLL, 16'h0005, 16'h0128},
    '{cpuTypesPkg::RTYPE, cpuTypesPkg::SRL, 16'h000D, 16'h012C},
    '{cpuTypesPkg::ADDI, cpuTypesPkg::ADD, 16'h8123, 16'h0130},  // Negative immediate
    '{cpuTypesPkg::ADDIU, cpuTypesPkg::ADD, 16'h7FFF, 16'h0134},
    '{cpuTypesPkg::ANDI, cpuTypesPkg::ADD, 16'hF0F0, 16'h0138},
    '{cpuTypesPkg::ORI, cpuTypesPkg::ADD, 16'h0FF0, 16'h013C},
    '{cpuTypesPkg::XORI, cpuTypesPkg::ADD, 16'h5A5A, 16'h0140},
    '{cpuTypesPkg::SLTI, cpuTypesPkg::ADD, 16'hFFF0, 16'h0144},
    '{cpuTypesPkg::SLTIU, cpuTypesPkg::ADD, 16'h8000, 16'h0148},
    '{cpuTypesPkg::LUI, cpuTypesPkg::ADD, 16'hBEEF, 16'h014C}
  };

  logic CLK = 1'b0;
  logic rstN;
  cpuTypesPkg::word_t imemLoad, dmemLoad, imemAddr, dmemAddr, dmemStore;
  logic dmemRen, dmemWen, halt;

  cpuTypesPkg::word_t imem [256];
  cpuTypesPkg::word_t dmem [256];
  cpuTypesPkg::word_t expAddr [$];
  cpuTypesPkg::word_t expData [$];
  cpuTypesPkg::word_t expReadAddr [$];
  cpuTypesPkg::word_t rngState = 32'h738a_3918;
  cpuTypesPkg::word_t opA, opB, lastResult;
  int pcIdx = 0;
  int jalIdx;
  int cycles = 0;
  int cycleLimit;

  always #20 CLK = ~CLK;

  singleCycleCpu DUT (
    .CLK(CLK), .rstN(rstN), .imemLoad(imemLoad), .dmemLoad(dmemLoad),
    .imemAddr(imemAddr), .dmemAddr(dmemAddr), .dmemStore(dmemStore),
    .dmemRen(dmemRen), .dmemWen(dmemWen), .halt(halt)
  );

  assign imemLoad = imem[imemAddr[9:2]];  // Combinational fetch
  assign dmemLoad = dmemRen ? dmem[dmemAddr[9:2]] : '0;  // Data only on a read request

  always @(posedge CLK) begin
    if (dmemWen) dmem[dmemAddr[9:2]] <= dmemStore;
  end

  task automatic stopWithFailure(input string reason);
    $display("*** TEST FAILED ***");
    $fatal(1, "%s", reason);
  endtask

  task automatic check(input string name, input cpuTypesPkg::word_t exp,
                       input cpuTypesPkg::word_t act);
    if (exp !== act) begin
      $display("ERROR at %0t: %s expected %h, actual %h", $time, name, exp, act);
      stopWithFailure("Value mismatch");
    end
  endtask

  function automatic cpuTypesPkg::word_t xorshift(input cpuTypesPkg::word_t s);
    cpuTypesPkg::word_t x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Expected result from the ALU and extension rules
  function automatic cpuTypesPkg::word_t refResult(input opRow_t r, input cpuTypesPkg::word_t a,
                                                   input cpuTypesPkg::word_t b);
    cpuTypesPkg::word_t se;
    cpuTypesPkg::word_t ze;
    se = {{16{r.imm[15]}}, r.imm};
    ze = {16'b0, r.imm};
    case (r.op)
      cpuTypesPkg::RTYPE: begin
        case (r.fn)
          cpuTypesPkg::ADD, cpuTypesPkg::ADDU: return a + b;
          cpuTypesPkg::SUB, cpuTypesPkg::SUBU: return a - b;
          cpuTypesPkg::AND: return a & b;
          cpuTypesPkg::OR: return a | b;
          cpuTypesPkg::XOR: return a ^ b;
          cpuTypesPkg::NOR: return ~(a | b);
          cpuTypesPkg::SLT: return {31'b0, $signed(a) < $signed(b)};
          cpuTypesPkg::SLTU: return {31'b0, a < b};
          cpuTypesPkg::SLL: return b << r.imm[4:0];  // Shifts act on rt
          cpuTypesPkg::SRL: return b >> r.imm[4:0];
          default: return '0;
        endcase
      end
      cpuTypesPkg::ADDI, cpuTypesPkg::ADDIU: return a + se;
      cpuTypesPkg::ANDI: return a & ze;
      cpuTypesPkg::ORI: return a | ze;
      cpuTypesPkg::XORI: return a ^ ze;
      cpuTypesPkg::SLTI: return {31'b0, $signed(a) < $signed(se)};
      cpuTypesPkg::SLTIU: return {31'b0, a < se};  // Sign extended, unsigned compare
      cpuTypesPkg::LUI: return {r.imm, 16'b0};
      default: return '0;
    endcase
  endfunction

  function automatic cpuTypesPkg::word_t rType(input cpuTypesPkg::funct_t fn,
                                               input cpuTypesPkg::regBits_t rs,
                                               input cpuTypesPkg::regBits_t rt,
                                               input cpuTypesPkg::regBits_t rd,
                                               input logic [4:0] shamt);
    return {cpuTypesPkg::RTYPE, rs, rt, rd, shamt, fn};
  endfunction

  function automatic cpuTypesPkg::word_t iType(input cpuTypesPkg::opcode_t op,
                                               input cpuTypesPkg::regBits_t rs,
                                               input cpuTypesPkg::regBits_t rt,
                                               input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic cpuTypesPkg::word_t jType(input cpuTypesPkg::opcode_t op, input int idx);
    return {op, idx[25:0]};  // Word index of the target
  endfunction

  task automatic emit(input cpuTypesPkg::word_t w);
    imem[pcIdx] = w;
    pcIdx++;
  endtask

  task automatic loadConst(input cpuTypesPkg::regBits_t rd, input cpuTypesPkg::word_t value);
    emit(iType(cpuTypesPkg::LUI, 5'd0, rd, value[31:16]));
    emit(iType(cpuTypesPkg::ORI, rd, rd, value[15:0]));
  endtask

  task automatic expectStore(input cpuTypesPkg::word_t addr, input cpuTypesPkg::word_t data);
    expAddr.push_back(addr);
    expData.push_back(data);
  endtask

  // Store and load checks at mid-cycle, plus the cycle budget
  always @(negedge CLK) begin
    if (rstN) begin
      cycles++;
      if (cycles > cycleLimit) begin
        stopWithFailure($sformatf("Timeout: the processor never halted in %0d cycles",
                                  cycleLimit));
      end else if (dmemWen) begin
        if (expAddr.size() == 0) begin
          stopWithFailure($sformatf("Unexpected data memory write at address %h", dmemAddr));
        end else begin
          check("dmemAddr", expAddr.pop_front(), dmemAddr);
          check("dmemStore", expData.pop_front(), dmemStore);
        end
      end else if (dmemRen) begin
        if (expReadAddr.size() == 0) begin
          stopWithFailure($sformatf("Unexpected data memory read at address %h", dmemAddr));
        end else begin
          check("dmemAddr", expReadAddr.pop_front(), dmemAddr);
        end
      end
    end
  end

  initial begin
    rstN = 1'b0;
    for (int i = 0; i < 256; i++) begin
      imem[i] = '0;
      dmem[i] = '0;
    end

    for (int i = 0; i < NUM_ROWS; i++) begin
      rngState = xorshift(rngState);
      opA = rngState;
      rngState = xorshift(rngState);
      opB = rngState;
      loadConst(5'd1, opA);
      loadConst(5'd2, opB);
      if (rows[i].op == cpuTypesPkg::RTYPE) begin
        emit(rType(rows[i].fn, 5'd1, 5'd2, 5'd3, rows[i].imm[4:0]));
      end else begin
        emit(iType(rows[i].op, 5'd1, 5'd3, rows[i].imm));
      end
      emit(iType(cpuTypesPkg::SW, 5'd0, 5'd3, rows[i].addr));
      lastResult = refResult(rows[i], opA, opB);
      expectStore({16'b0, rows[i].addr}, lastResult);
    end

    // Load back the last result and copy it
    emit(iType(cpuTypesPkg::LW, 5'd0, 5'd4, rows[NUM_ROWS-1].addr));
    expReadAddr.push_back({16'b0, rows[NUM_ROWS-1].addr});
    emit(iType(cpuTypesPkg::SW, 5'd0, 5'd4, 16'h0200));
    expectStore(32'h0200, lastResult);

    // Branches and jumps around marker stores
    emit(iType(cpuTypesPkg::ORI, 5'd0, 5'd5, 16'h00AA));
    emit(iType(cpuTypesPkg::BEQ, 5'd0, 5'd0, 16'd1));  // Taken
    emit(iType(cpuTypesPkg::SW, 5'd0, 5'd5, 16'h0204));
    emit(iType(cpuTypesPkg::BEQ, 5'd0, 5'd5, 16'd1));  // Not taken
    emit(iType(cpuTypesPkg::SW, 5'd0, 5'd5, 16'h0208));
    expectStore(32'h0208, 32'h00AA);
    emit(iType(cpuTypesPkg::BNE, 5'd0, 5'd5, 16'd1));  // Taken
    emit(iType(cpuTypesPkg::SW, 5'd0, 5'd5, 16'h020C));
    emit(iType(cpuTypesPkg::BNE, 5'd0, 5'd0, 16'd1));  // Not taken
    emit(iType(cpuTypesPkg::SW, 5'd0, 5'd5, 16'h0210));
    expectStore(32'h0210, 32'h00AA);
    emit(jType(cpuTypesPkg::J, pcIdx + 2));
    emit(iType(cpuTypesPkg::SW, 5'd0, 5'd5, 16'h0214));

    // JAL to a JR placed after HALT, then store the link value
    jalIdx = pcIdx;
    emit(jType(cpuTypesPkg::JAL, jalIdx + 5));
    emit(iType(cpuTypesPkg::SW, 5'd0, 5'd31, 16'h0218));
    expectStore(32'h0218, (jalIdx + 1) * 4);
    emit(iType(cpuTypesPkg::ORI, 5'd0, 5'd0, 16'h1234));  // r0 must ignore this
    emit(iType(cpuTypesPkg::SW, 5'd0, 5'd0, 16'h021C));
    expectStore(32'h021C, 32'h0);
    emit({cpuTypesPkg::HALT, 26'b0});
    emit(rType(cpuTypesPkg::JR, 5'd31, 5'd0, 5'd0, 5'd0));

    cycleLimit = 2 * pcIdx + 20;
    repeat (3) @(negedge CLK);
    rstN = 1'b1;

    while (!halt) @(negedge CLK);
    repeat (5) begin
      @(negedge CLK);
      check("halt", 32'd1, halt);
      check("dmemWen", 32'd0, dmemWen);
      check("dmemRen", 32'd0, dmemRen);
    end

    check("loaded word", lastResult, dmem[rows[NUM_ROWS-1].addr[9:2]]);
    check("copied word", lastResult, dmem[32'h0200 >> 2]);
    check("skipped BEQ store", 32'h0, dmem[32'h0204 >> 2]);
    check("skipped BNE store", 32'h0, dmem[32'h020C >> 2]);
    check("skipped J store", 32'h0, dmem[32'h0214 >> 2]);

    if (expAddr.size() != 0) begin
      stopWithFailure($sformatf("%0d expected stores never happened", expAddr.size()));
    end else if (expReadAddr.size() != 0) begin
      stopWithFailure("The expected load from data memory never happened");
    end else begin
      $display("*** TEST PASSED ***");
      $finish;
    end
  end

endmodule

// File: files.f
source/cpuTypesPkg.sv
source/controlUnit.sv
source/alu.sv
source/registerFile.sv
source/programCounter.sv
source/singleCycleCpu.sv
test/cpuTb.sv

// File: Bender.yml
package:
  name: single_cycle_cpu

sources:
  - source/cpuTypesPkg.sv
  - source/controlUnit.sv
  - source/alu.sv
  - source/registerFile.sv
  - source/programCounter.sv
  - source/singleCycleCpu.sv
  - target: test
    files:
      - test/cpuTb.sv
